/* src/player_pkg.sv */
package player_pkg;

  // ============================================================
  // Flash bus widths
  // ============================================================

  // Word address into the 32-bit flash
  localparam int ADDR_W = 23;

  localparam int DATA_W = 32;

  // ============================================================
  // Audio path widths
  // ============================================================

  localparam int SAMPLE_W = 8;

  // Enough for periods well beyond the 44 kHz rate at 50 MHz
  localparam int PERIOD_W = 16;

  // ============================================================
  // Shared types
  // ============================================================

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] word_t;
  typedef logic [SAMPLE_W-1:0] sample_t;
  typedef logic [PERIOD_W-1:0] period_t;

endpackage

/* src/speed_decode.sv */
module speed_decode #(
  parameter int unsigned REPEAT_TICKS = 5000000
) (
  input  logic clk,
  input  logic rst,
  input  logic speed_up,
  input  logic speed_down,
  output logic step_up,
  output logic step_down
);

  localparam int CNT_W = (REPEAT_TICKS > 1) ? $clog2(REPEAT_TICKS) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(REPEAT_TICKS - 1);

  logic [CNT_W-1:0] repeat_cnt;
  logic             wrap;

  // Keys are sampled only once per repeat interval
  assign wrap = (repeat_cnt == CNT_LAST);

  always_ff @(posedge clk) begin
    if (rst) begin
      repeat_cnt <= '0;
    end else if (wrap) begin
      repeat_cnt <= '0;
    end else begin
      repeat_cnt <= repeat_cnt + 1'b1;
    end
  end

  // One step pulse per interval while a key stays held
  always_ff @(posedge clk) begin
    if (rst) begin
      step_up   <= 1'b0;
      step_down <= 1'b0;
    end else begin
      step_up   <= wrap & speed_up;
      step_down <= wrap & speed_down;
    end
  end

endmodule

/* src/rate_control.sv */
module rate_control #(
  parameter player_pkg::period_t BASE_PERIOD = 16'd1136,
  parameter player_pkg::period_t SPEED_STEP  = 16'd100,
  parameter player_pkg::period_t MIN_PERIOD  = 16'd236,
  parameter player_pkg::period_t MAX_PERIOD  = 16'd5036
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                step_up,
  input  logic                step_down,
  input  logic                speed_reset,
  output player_pkg::period_t sample_period,
  output logic                tick
);

  // One extra bit so the clamp arithmetic cannot wrap
  localparam int EXT_W = player_pkg::PERIOD_W + 1;
  localparam logic [EXT_W-1:0] UP_FLOOR = {1'b0, MIN_PERIOD} + {1'b0, SPEED_STEP};

  logic [EXT_W-1:0]    down_sum;
  player_pkg::period_t period_next;
  player_pkg::period_t tick_cnt;
  logic                tick_wrap;

  // ============================================================
  // Sample period register
  // ============================================================

  assign down_sum = {1'b0, sample_period} + {1'b0, SPEED_STEP};

  always_comb begin
    period_next = sample_period;
    if (step_up && !step_down) begin
      // Faster playback, shorter period
      if ({1'b0, sample_period} < UP_FLOOR) begin
        period_next = MIN_PERIOD;
      end else begin
        period_next = sample_period - SPEED_STEP;
      end
    end else if (step_down && !step_up) begin
      if (down_sum > {1'b0, MAX_PERIOD}) begin
        period_next = MAX_PERIOD;
      end else begin
        period_next = down_sum[player_pkg::PERIOD_W-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst || speed_reset) begin
      sample_period <= BASE_PERIOD;
    end else begin
      sample_period <= period_next;
    end
  end

  // ============================================================
  // Sample tick
  // ============================================================

  // Compare with >= so a shortened period never lets the count run away
  assign tick_wrap = (tick_cnt >= sample_period - 1'b1);

  always_ff @(posedge clk) begin
    if (rst) begin
      tick_cnt <= '0;
      tick     <= 1'b0;
    end else begin
      tick_cnt <= tick_wrap ? '0 : tick_cnt + 1'b1;
      tick     <= tick_wrap;
    end
  end

endmodule

/* src/flash_reader.sv */
module flash_reader #(
  parameter player_pkg::addr_t LAST_ADDR = 23'h7FFFF
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              dir,
  input  logic              tick,
  input  logic              flash_waitrequest,
  input  logic              flash_readdatavalid,
  output logic              flash_read,
  output player_pkg::addr_t flash_address,
  output logic              take,
  output logic              take_high,
  output logic              take_zero
);

  typedef enum logic [1:0] {
    ST_IDLE    = 2'b00,
    ST_READY   = 2'b01,
    ST_READING = 2'b10,
    ST_DONE    = 2'b11
  } state_t;

  state_t state;

  // Which byte of the current word comes next, 1 selects [23:16]
  logic half;
  logic at_end;

  // ============================================================
  // End of range detection
  // ============================================================

  // Forward stops on the high byte of the last word,
  // reverse stops on the low byte of word zero
  always_comb begin
    if (dir) begin
      at_end = !half && (flash_address == '0);
    end else begin
      at_end = half && (flash_address == LAST_ADDR);
    end
  end

  // Byte choice is presented while in the done phase
  assign take      = (state == ST_DONE);
  assign take_high = half;
  assign take_zero = at_end;

  // ============================================================
  // Read sequencer and position walk
  // ============================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ST_IDLE;
      flash_read <= 1'b0;
      // Start position depends on playback direction at reset
      if (dir) begin
        flash_address <= LAST_ADDR;
        half          <= 1'b1;
      end else begin
        flash_address <= '0;
        half          <= 1'b0;
      end
    end else begin
      flash_read <= 1'b0;

      case (state)
        ST_IDLE: begin
          // Ticks are only accepted here, others are dropped
          if (tick && !flash_waitrequest) begin
            state <= ST_READY;
          end
        end

        ST_READY: begin
          // Hold off the strobe while the memory is stalling
          if (!flash_waitrequest) begin
            flash_read <= 1'b1;
            state      <= ST_READING;
          end
        end

        ST_READING: begin
          // Address stays put until the word comes back
          if (flash_readdatavalid) begin
            state <= ST_DONE;
          end
        end

        ST_DONE: begin
          state <= ST_IDLE;
          if (!at_end) begin
            half <= ~half;
            if (dir && !half) begin
              flash_address <= flash_address - 1'b1;
            end else if (!dir && half) begin
              flash_address <= flash_address + 1'b1;
            end
          end
        end

        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

/* src/sample_select.sv */
module sample_select (
  input  logic                clk,
  input  logic                rst,
  input  logic                take,
  input  logic                take_high,
  input  logic                take_zero,
  input  player_pkg::word_t   flash_readdata,
  output player_pkg::sample_t audio,
  output logic                audio_valid
);

  // Bit positions of the two samples packed in a flash word
  localparam int LOW_LSB  = 0;
  localparam int HIGH_LSB = 16;

  player_pkg::sample_t low_byte;
  player_pkg::sample_t high_byte;
  player_pkg::sample_t chosen;

  assign low_byte  = flash_readdata[LOW_LSB +: player_pkg::SAMPLE_W];
  assign high_byte = flash_readdata[HIGH_LSB +: player_pkg::SAMPLE_W];

  // Silence once the reader has run off the end of the range
  always_comb begin
    if (take_zero) begin
      chosen = '0;
    end else if (take_high) begin
      chosen = high_byte;
    end else begin
      chosen = low_byte;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      audio       <= '0;
      audio_valid <= 1'b0;
    end else begin
      audio_valid <= take;
      if (take) begin
        audio <= chosen;
      end
    end
  end

endmodule

/* src/audio_player_top.sv */
module audio_player_top #(
  parameter player_pkg::addr_t   LAST_ADDR    = 23'h7FFFF,
  parameter player_pkg::period_t BASE_PERIOD  = 16'd1136,
  parameter player_pkg::period_t SPEED_STEP   = 16'd100,
  parameter player_pkg::period_t MIN_PERIOD   = 16'd236,
  parameter player_pkg::period_t MAX_PERIOD   = 16'd5036,
  parameter int unsigned         REPEAT_TICKS = 5000000
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                dir,
  input  logic                speed_up,
  input  logic                speed_down,
  input  logic                speed_reset,
  input  logic                flash_waitrequest,
  input  player_pkg::word_t   flash_readdata,
  input  logic                flash_readdatavalid,
  output logic                flash_read,
  output player_pkg::addr_t   flash_address,
  output player_pkg::sample_t audio,
  output logic                audio_valid,
  output player_pkg::period_t sample_period
);

  logic step_up;
  logic step_down;
  logic tick;
  logic take;
  logic take_high;
  logic take_zero;

  // ============================================================
  // Decode, held keys to step pulses
  // ============================================================

  speed_decode #(
    .REPEAT_TICKS (REPEAT_TICKS)
  ) speed_decode0 (
    .clk        (clk),
    .rst        (rst),
    .speed_up   (speed_up),
    .speed_down (speed_down),
    .step_up    (step_up),
    .step_down  (step_down)
  );

  // ============================================================
  // Execute, sample rate and flash walk
  // ============================================================

  rate_control #(
    .BASE_PERIOD (BASE_PERIOD),
    .SPEED_STEP  (SPEED_STEP),
    .MIN_PERIOD  (MIN_PERIOD),
    .MAX_PERIOD  (MAX_PERIOD)
  ) rate_control0 (
    .clk           (clk),
    .rst           (rst),
    .step_up       (step_up),
    .step_down     (step_down),
    .speed_reset   (speed_reset),
    .sample_period (sample_period),
    .tick          (tick)
  );

  flash_reader #(
    .LAST_ADDR (LAST_ADDR)
  ) flash_reader0 (
    .clk                 (clk),
    .rst                 (rst),
    .dir                 (dir),
    .tick                (tick),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdatavalid (flash_readdatavalid),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .take                (take),
    .take_high           (take_high),
    .take_zero           (take_zero)
  );

  // Result, byte pick straight off the flash data bus
  sample_select sample_select0 (
    .clk            (clk),
    .rst            (rst),
    .take           (take),
    .take_high      (take_high),
    .take_zero      (take_zero),
    .flash_readdata (flash_readdata),
    .audio          (audio),
    .audio_valid    (audio_valid)
  );

endmodule

/* testbench/tb_flash_model.sv */
module tb_flash_model #(
  parameter logic [31:0] SEED = 32'h3f9ec0bd
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                fast,
  input  logic                read,
  input  player_pkg::addr_t   address,
  output logic                waitrequest,
  output player_pkg::word_t   readdata,
  output logic                readdatavalid
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [31:0]       rnd;
  logic [2:0]        wait_cnt;
  logic              pending;
  player_pkg::addr_t addr_q;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Samples 3a+1 in [7:0] and 5a+2 in [23:16], filler in the other bytes
  function automatic player_pkg::word_t word_at(input player_pkg::addr_t a);
    return {8'hA5, 8'(5 * a + 2), 8'h5A, 8'(3 * a + 1)};
  endfunction

  initial rnd = SEED;

  // Outputs change on the falling edge, the DUT samples on the rising one
  always @(negedge clk) begin
    rnd = xorshift32(rnd);
    readdatavalid <= 1'b0;
    waitrequest   <= fast ? 1'b0 : (rnd[1:0] == 2'b00);
    if (rst) begin
      pending  <= 1'b0;
      readdata <= '0;
    end else if (pending) begin
      if (wait_cnt <= 3'd1) begin
        readdatavalid <= 1'b1;
        readdata      <= word_at(addr_q);
        pending       <= 1'b0;
      end else begin
        wait_cnt <= wait_cnt - 1'b1;
      end
    end else if (read) begin
      // Latency of 1 to 6 cycles, always 1 in fast mode
      pending <= 1'b1;
      addr_q  <= address;
      if (fast || rnd[10:8] == 3'd0 || rnd[10:8] == 3'd7) begin
        wait_cnt <= 3'd1;
      end else begin
        wait_cnt <= rnd[10:8];
      end
    end
  end

endmodule

/* testbench/tb_audio_player.sv */
module tb_audio_player;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RPT = 16;
  // Slow playback, lost ticks and long speed holds, with a wide margin
  localparam int WATCHDOG_NS = (3 * 34 * 64 * 4 + 40 * RPT + 20 * 64) * 10 * 2;

  logic clk = 1'b0;
  logic rst;
  logic dir;
  logic speed_up;
  logic speed_down;
  logic speed_reset;
  logic fast;
  logic flash_waitrequest;
  logic flash_readdatavalid;
  logic flash_read;
  logic audio_valid;
  player_pkg::word_t   flash_readdata;
  player_pkg::addr_t   flash_address;
  player_pkg::sample_t audio;
  player_pkg::period_t sample_period;
  logic outstanding;
  logic spacing_on;
  logic seen_read;
  logic seen_audio;
  int   audio_count;
  int   read_gap;
  int   audio_gap;
  int   error_count;
  int   test_count;

  always #5 clk = ~clk;

  audio_player_top #(
    .LAST_ADDR    (23'd15),
    .BASE_PERIOD  (16'd40),
    .SPEED_STEP   (16'd4),
    .MIN_PERIOD   (16'd24),
    .MAX_PERIOD   (16'd64),
    .REPEAT_TICKS (RPT)
  ) dut0 (
    .clk                 (clk),
    .rst                 (rst),
    .dir                 (dir),
    .speed_up            (speed_up),
    .speed_down          (speed_down),
    .speed_reset         (speed_reset),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .audio               (audio),
    .audio_valid         (audio_valid),
    .sample_period       (sample_period)
  );

  tb_flash_model flash0 (
    .clk           (clk),
    .rst           (rst),
    .fast          (fast),
    .read          (flash_read),
    .address       (flash_address),
    .waitrequest   (flash_waitrequest),
    .readdata      (flash_readdata),
    .readdatavalid (flash_readdatavalid)
  );

  // Forward n-th sample low(0), high(0), low(1)..., reverse starts at high(15)
  function automatic logic [7:0] expected_sample(input logic rev, input int n);
    int a;
    if (n >= 31) return 8'd0;
    a = rev ? 15 - n / 2 : n / 2;
    if ((n % 2 == 0) != rev) return 8'(3 * a + 1);
    return 8'(5 * a + 2);
  endfunction

  task automatic report_mismatch(input string name, input int got, input int exp);
    $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
    error_count++;
  endtask

  task automatic report_problem(input string what);
    $display("%0t %s", $time, what);
    error_count++;
  endtask

  // Bookkeeping for the protocol and spacing checks
  always @(posedge clk) begin
    if (rst) begin
      outstanding <= 1'b0;
      audio_count <= 0;
    end else begin
      if (flash_read) begin
        outstanding <= 1'b1;
      end else if (flash_readdatavalid) begin
        outstanding <= 1'b0;
      end
      if (audio_valid) begin
        audio_count <= audio_count + 1;
      end
    end
    read_gap   <= flash_read ? 1 : read_gap + 1;
    audio_gap  <= audio_valid ? 1 : audio_gap + 1;
    seen_read  <= spacing_on && (seen_read || flash_read);
    seen_audio <= spacing_on && (seen_audio || audio_valid);
  end

  // ============================================================
  // Checks
  // ============================================================

  a_audio: assert property (@(posedge clk) disable iff (rst)
    audio_valid |-> audio == expected_sample(dir, audio_count))
    else report_mismatch("audio", $sampled(audio),
                         expected_sample(dir, $sampled(audio_count)));
  a_b2b: assert property (@(posedge clk) disable iff (rst) flash_read |-> !$past(flash_read))
    else report_problem("flash_read was high two cycles in a row");
  a_outst: assert property (@(posedge clk) disable iff (rst) flash_read |-> !outstanding)
    else report_problem("flash_read issued while a read was outstanding");
  a_wait: assert property (@(posedge clk) disable iff (rst)
    flash_read |-> !$past(flash_waitrequest))
    else report_problem("flash_read issued right after waitrequest was high");
  a_addr: assert property (@(posedge clk) disable iff (rst) outstanding |-> $stable(flash_address))
    else report_mismatch("flash_address", $sampled(flash_address), $past(flash_address));
  a_range: assert property (@(posedge clk) disable iff (rst)
    sample_period >= 24 && sample_period <= 64)
    else report_problem("sample_period left the 24 to 64 range");
  a_step: assert property (@(posedge clk) disable iff (rst)
    !$stable(sample_period) |-> sample_period == $past(sample_period) - 4 ||
      sample_period == $past(sample_period) + 4 || sample_period == 40)
    else report_problem("sample_period changed by something other than one step");
  a_rgap: assert property (@(posedge clk) disable iff (rst)
    flash_read && seen_read |-> read_gap >= sample_period)
    else report_mismatch("read_gap", $sampled(read_gap), $sampled(sample_period));
  a_agap: assert property (@(posedge clk) disable iff (rst)
    audio_valid && seen_audio |-> audio_gap == sample_period)
    else report_mismatch("audio_gap", $sampled(audio_gap), $sampled(sample_period));

  task automatic check_reset_values();
    assert (!flash_read && !audio_valid && audio == 0)
      else report_problem("outputs not idle after reset");
    assert (sample_period == 40) else report_mismatch("sample_period", sample_period, 40);
  endtask

  task automatic apply_reset(input logic rev, input logic quick);
    rst = 1'b1;
    dir = rev;
    fast = quick;
    repeat (5) @(negedge clk);
    rst = 1'b0;
    // First cycle out of reset
    @(negedge clk);
    check_reset_values();
  endtask

  task automatic wait_samples(input int n);
    while (audio_count < n) begin
      @(negedge clk);
    end
  endtask

  task automatic finish_test(input string name);
    test_count++;
    $display("test %0d %s finished, %0d errors so far", test_count, name, error_count);
  endtask

  task automatic hold_keys(input logic up, input logic down, input int intervals);
    speed_up = up;
    speed_down = down;
    repeat (intervals * RPT) @(negedge clk);
    speed_up = 1'b0;
    speed_down = 1'b0;
    repeat (2 * RPT) @(negedge clk);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the tests completed");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    {rst, dir, speed_up, speed_down, speed_reset, fast, spacing_on} = '0;
    error_count = 0;
    test_count = 0;
    read_gap = 0;
    audio_gap = 0;
    apply_reset(1'b0, 1'b0);
    wait_samples(34);
    finish_test("forward order");
    hold_keys(1'b1, 1'b0, 8);
    assert (sample_period == 24) else report_mismatch("sample_period", sample_period, 24);
    speed_reset = 1'b1;
    repeat (2) @(negedge clk);
    speed_reset = 1'b0;
    assert (sample_period == 40) else report_mismatch("sample_period", sample_period, 40);
    // Both keys from mid range, neither direction may win
    hold_keys(1'b1, 1'b1, 4);
    assert (sample_period == 40) else report_mismatch("sample_period", sample_period, 40);
    hold_keys(1'b0, 1'b1, 14);
    assert (sample_period == 64) else report_mismatch("sample_period", sample_period, 64);
    finish_test("speed steps");
    // Period sits at its maximum going into this reset
    apply_reset(1'b1, 1'b0);
    wait_samples(34);
    finish_test("reverse order and read protocol");
    apply_reset(1'b0, 1'b1);
    spacing_on = 1'b1;
    wait_samples(12);
    spacing_on = 1'b0;
    finish_test("tick spacing");
    // Reset in mid playback while audio still holds a sample
    apply_reset(1'b0, 1'b0);
    finish_test("reset values");
    $display("%0d tests run, %0d checks failed", test_count, error_count);
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* vlog.f */
src/player_pkg.sv
src/speed_decode.sv
src/rate_control.sv
src/flash_reader.sv
src/sample_select.sv
src/audio_player_top.sv
testbench/tb_flash_model.sv
testbench/tb_audio_player.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing -j 0
TOP       ?= tb_audio_player
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
